// ==== rtl/aib_adapttxdp_pkg.sv ====
// Adapter TX datapath FIFO definitions
`default_nettype none

package aib_adapttxdp_pkg;

   //****************************************
   // Sizes
   //****************************************
   localparam int DWIDTH = 80;                 // Bits per lane
   localparam int AWIDTH = 4;                  // Pointer and count width
   localparam int DEPTH  = 1 << AWIDTH;        // RAM entries, 16
   localparam int LANES  = 4;                  // Lanes per stored word

   //****************************************
   // Vector types
   //****************************************

   // One lane as seen on rd_data
   typedef logic [DWIDTH-1:0] lane_data_t;

   // Full stored word, lane 0 in the low bits
   typedef logic [LANES*DWIDTH-1:0] wide_data_t;

   // Pointers, occupancy counts and thresholds
   typedef logic [AWIDTH-1:0] ptr_t;

   // One-hot entry select into the flop RAM
   typedef logic [DEPTH-1:0] onehot_t;

   //****************************************
   // Read ratio modes
   //****************************************
   typedef enum logic [1:0] {
      FIFO_1X = 2'd0,                          // Full rate, lane 0 only
      FIFO_2X = 2'd1,                          // Half rate, lanes 0 and 1
      FIFO_4X = 2'd2,                          // Quarter rate, all four lanes
      REG_MOD = 2'd3                           // Register mode, reads as 1:1
   } fifo_mode_e;

endpackage

`default_nettype wire

// ==== rtl/aib_adapttxdp_fifo_ram.sv ====
// Flop based FIFO storage
`timescale 1ns/1ps
`default_nettype none

module aib_adapttxdp_fifo_ram (
   input  logic                          wr_clk,    // Write domain clock
   input  logic                          wr_rst_n,  // Write domain reset
   input  logic                          wr_en,     // Store strobe
   input  aib_adapttxdp_pkg::onehot_t    wr_ptr,    // One-hot write entry
   input  aib_adapttxdp_pkg::wide_data_t wr_data,   // Word to store
   input  aib_adapttxdp_pkg::onehot_t    rd_ptr,    // One-hot read entry
   output aib_adapttxdp_pkg::wide_data_t rd_data    // Selected word
);

   import aib_adapttxdp_pkg::*;

   localparam int WWIDTH = LANES * DWIDTH;  // Bits per stored word

   wide_data_t mem [DEPTH];                 // Storage array

   //****************************************
   // Write port
   //****************************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;                   // Whole array cleared
         end
      end else begin
         for (int i = 0; i < DEPTH; i++) begin
            if (wr_en && wr_ptr[i]) begin
               mem[i] <= wr_data;           // Only the selected entry loads
            end
         end
      end
   end

   //****************************************
   // Read port
   //****************************************

   // AND-OR mux, one select bit per entry
   always_comb begin
      rd_data = '0;
      for (int i = 0; i < DEPTH; i++) begin
         rd_data = rd_data | ({WWIDTH{rd_ptr[i]}} & mem[i]);
      end
   end

endmodule

`default_nettype wire

// ==== rtl/aib_adapttxdp_fifo_ptr.sv ====
// FIFO pointers and occupancy
`timescale 1ns/1ps
`default_nettype none

module aib_adapttxdp_fifo_ptr (
   input  logic                       wr_clk,          // Write domain clock
   input  logic                       wr_rst_n,        // Write domain reset
   input  logic                       rd_clk,          // Read domain clock
   input  logic                       rd_rst_n,        // Read domain reset
   input  logic                       wr_en,           // Write pointer step
   input  logic                       rd_en,           // Read pointer step
   output aib_adapttxdp_pkg::onehot_t wr_ptr_one_hot,  // RAM write select
   output aib_adapttxdp_pkg::onehot_t rd_ptr_one_hot,  // RAM read select
   output aib_adapttxdp_pkg::ptr_t    wr_numdata,      // Occupancy, write side
   output aib_adapttxdp_pkg::ptr_t    rd_numdata       // Occupancy, read side
);

   import aib_adapttxdp_pkg::*;

   // Gray back to binary, MSB down
   function automatic ptr_t gray2bin(input ptr_t gray);
      ptr_t bin;
      bin[AWIDTH-1] = gray[AWIDTH-1];
      for (int i = AWIDTH - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

   // Write domain
   ptr_t wr_bin;         // Binary write pointer
   ptr_t wr_bin_next;
   ptr_t wr_gray;        // Registered gray copy, crosses to read side
   ptr_t rd_gray_s1;     // Read pointer synchronizer, first stage
   ptr_t rd_gray_s2;     // Second stage
   ptr_t rd_bin_wr;      // Read pointer as seen by the write side

   // Read domain
   ptr_t rd_bin;         // Binary read pointer
   ptr_t rd_bin_next;
   ptr_t rd_gray;        // Registered gray copy, crosses to write side
   ptr_t wr_gray_s1;     // Write pointer synchronizer, first stage
   ptr_t wr_gray_s2;     // Second stage
   ptr_t wr_bin_rd;      // Write pointer as seen by the read side

   //****************************************
   // Write clock domain
   //****************************************
   assign wr_bin_next = wr_bin + {{(AWIDTH-1){1'b0}}, wr_en};

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end else begin
         wr_bin  <= wr_bin_next;
         wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);  // Glitch-free crossing
      end
   end

   // Two-flop synchronizer for the read pointer
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end else begin
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
      end
   end

   assign rd_bin_wr      = gray2bin(rd_gray_s2);
   assign wr_numdata     = wr_bin - rd_bin_wr;       // Wraps modulo DEPTH
   assign wr_ptr_one_hot = onehot_t'(1) << wr_bin;

   //****************************************
   // Read clock domain
   //****************************************
   assign rd_bin_next = rd_bin + {{(AWIDTH-1){1'b0}}, rd_en};

   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end else begin
         rd_bin  <= rd_bin_next;
         rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
      end
   end

   // Two-flop synchronizer for the write pointer
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end else begin
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
      end
   end

   assign wr_bin_rd      = gray2bin(wr_gray_s2);
   assign rd_numdata     = wr_bin_rd - rd_bin;       // Lags real occupancy
   assign rd_ptr_one_hot = onehot_t'(1) << rd_bin;

endmodule

`default_nettype wire

// ==== rtl/aib_adapttxdp_async_fifo.sv ====
// Ratio read async FIFO
`timescale 1ns/1ps
`default_nettype none

module aib_adapttxdp_async_fifo (
   input  logic                          wr_clk,       // Write domain clock
   input  logic                          wr_rst_n,     // Write domain reset
   input  logic                          wr_en,        // Push one wide word
   input  aib_adapttxdp_pkg::wide_data_t wr_data,      // Four lanes in
   input  logic                          rd_clk,       // Read domain clock
   input  logic                          rd_rst_n,     // Read domain reset
   input  logic                          rd_en,        // Pop one lane
   input  aib_adapttxdp_pkg::ptr_t       r_empty,      // Empty threshold
   input  aib_adapttxdp_pkg::ptr_t       r_pempty,     // Partially empty threshold
   input  aib_adapttxdp_pkg::ptr_t       r_full,       // Full threshold
   input  aib_adapttxdp_pkg::ptr_t       r_pfull,      // Partially full threshold
   input  aib_adapttxdp_pkg::fifo_mode_e r_fifo_mode,  // Read ratio
   output aib_adapttxdp_pkg::lane_data_t rd_data,      // One lane out
   output logic                          wr_empty,
   output logic                          wr_pempty,
   output logic                          wr_full,
   output logic                          wr_pfull,
   output logic                          rd_empty,
   output logic                          rd_pempty,
   output logic                          rd_full,
   output logic                          rd_pfull
);

   import aib_adapttxdp_pkg::*;

   onehot_t    wr_ptr_one_hot;   // RAM write select
   onehot_t    rd_ptr_one_hot;   // RAM read select
   ptr_t       wr_numdata;       // Occupancy in write clock
   ptr_t       rd_numdata;       // Occupancy in read clock
   wide_data_t rd_data_wide;     // Word at the read pointer
   logic [1:0] rd_cnt;           // Lane counter within a word
   logic [1:0] lane_sel;         // Lane driven onto rd_data
   logic       full_rd_en;       // Read pointer step

   //****************************************
   // Storage and pointers
   //****************************************
   aib_adapttxdp_fifo_ram u_ram (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .wr_en    (wr_en),
      .wr_ptr   (wr_ptr_one_hot),
      .wr_data  (wr_data),
      .rd_ptr   (rd_ptr_one_hot),
      .rd_data  (rd_data_wide)
   );

   aib_adapttxdp_fifo_ptr u_ptr (
      .wr_clk         (wr_clk),
      .wr_rst_n       (wr_rst_n),
      .rd_clk         (rd_clk),
      .rd_rst_n       (rd_rst_n),
      .wr_en          (wr_en),
      .rd_en          (full_rd_en),     // Steps once per word, not per lane
      .wr_ptr_one_hot (wr_ptr_one_hot),
      .rd_ptr_one_hot (rd_ptr_one_hot),
      .wr_numdata     (wr_numdata),
      .rd_numdata     (rd_numdata)
   );

   //****************************************
   // Read ratio counter
   //****************************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_cnt <= 2'd0;
      end else if (rd_en) begin
         rd_cnt <= rd_cnt + 2'd1;        // Free running, mode picks the bits
      end
   end

   // Pointer moves on the last lane of a word
   always_comb begin
      case (r_fifo_mode)
         FIFO_2X: full_rd_en = rd_en & rd_cnt[0];
         FIFO_4X: full_rd_en = rd_en & (rd_cnt == 2'd3);
         default: full_rd_en = rd_en;    // 1:1 and register mode
      endcase
   end

   //****************************************
   // Lane select
   //****************************************
   always_comb begin
      case (r_fifo_mode)
         FIFO_2X: lane_sel = {1'b0, rd_cnt[0]};
         FIFO_4X: lane_sel = rd_cnt;
         default: lane_sel = 2'd0;
      endcase
   end

   assign rd_data = rd_data_wide[lane_sel*DWIDTH +: DWIDTH];

   // Write side flags, one cycle behind wr_numdata
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_empty  <= 1'b1;
         wr_pempty <= 1'b1;
         wr_full   <= 1'b0;
         wr_pfull  <= 1'b0;
      end else begin
         wr_empty  <= (wr_numdata <= r_empty);
         wr_pempty <= (wr_numdata <= r_pempty);
         wr_full   <= (wr_numdata >= r_full);
         wr_pfull  <= (wr_numdata >= r_pfull);
      end
   end

   // Read side flags, from synchronized write pointer
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_empty  <= 1'b1;
         rd_pempty <= 1'b1;
         rd_full   <= 1'b0;
         rd_pfull  <= 1'b0;
      end else begin
         rd_empty  <= (rd_numdata <= r_empty);   // Low means data to read
         rd_pempty <= (rd_numdata <= r_pempty);
         rd_full   <= (rd_numdata >= r_full);
         rd_pfull  <= (rd_numdata >= r_pfull);
      end
   end

endmodule

`default_nettype wire

// ==== rtl/aib_adapttxdp_top.sv ====
// Adapter TX datapath top
`timescale 1ns/1ps
`default_nettype none

module aib_adapttxdp_top (
   input  logic                          wr_clk,
   input  logic                          wr_rst_n,
   input  logic                          wr_en,
   input  aib_adapttxdp_pkg::wide_data_t wr_data,
   input  logic                          rd_clk,
   input  logic                          rd_rst_n,
   input  logic                          rd_en,
   input  aib_adapttxdp_pkg::ptr_t       r_empty,      // Static thresholds
   input  aib_adapttxdp_pkg::ptr_t       r_pempty,
   input  aib_adapttxdp_pkg::ptr_t       r_full,
   input  aib_adapttxdp_pkg::ptr_t       r_pfull,
   input  aib_adapttxdp_pkg::fifo_mode_e r_fifo_mode,  // Change only in reset
   output aib_adapttxdp_pkg::lane_data_t rd_data,
   output logic                          wr_empty,
   output logic                          wr_pempty,
   output logic                          wr_full,
   output logic                          wr_pfull,
   output logic                          rd_empty,
   output logic                          rd_pempty,
   output logic                          rd_full,
   output logic                          rd_pfull
);

   aib_adapttxdp_async_fifo u_fifo (
      .wr_clk      (wr_clk),
      .wr_rst_n    (wr_rst_n),
      .wr_en       (wr_en),
      .wr_data     (wr_data),
      .rd_clk      (rd_clk),
      .rd_rst_n    (rd_rst_n),
      .rd_en       (rd_en),
      .r_empty     (r_empty),
      .r_pempty    (r_pempty),
      .r_full      (r_full),
      .r_pfull     (r_pfull),
      .r_fifo_mode (r_fifo_mode),
      .rd_data     (rd_data),
      .wr_empty    (wr_empty),
      .wr_pempty   (wr_pempty),
      .wr_full     (wr_full),
      .wr_pfull    (wr_pfull),
      .rd_empty    (rd_empty),
      .rd_pempty   (rd_pempty),
      .rd_full     (rd_full),
      .rd_pfull    (rd_pfull)
   );

endmodule

`default_nettype wire

// ==== dv/aib_adapttxdp_tb.sv ====
// Adapter TX datapath FIFO testbench
`timescale 1ns/1ps
`default_nettype none

module aib_adapttxdp_tb;

   import aib_adapttxdp_pkg::*;

   localparam int clk_period    = 10;    // Clock period in ns for both domains
   localparam int num_tests     = 6;
   localparam int budget_cycles = 330;   // Cycle budget per test

   logic       wr_clk = 1'b0;
   logic       rd_clk = 1'b0;
   logic       wr_rst_n;
   logic       rd_rst_n;
   logic       wr_en;
   logic       rd_en;
   wide_data_t wr_data;
   ptr_t       r_empty;
   ptr_t       r_pempty;
   ptr_t       r_full;
   ptr_t       r_pfull;
   fifo_mode_e r_fifo_mode;
   lane_data_t rd_data;
   logic       wr_empty;
   logic       wr_pempty;
   logic       wr_full;
   logic       wr_pfull;
   logic       rd_empty;
   logic       rd_pempty;
   logic       rd_full;
   logic       rd_pfull;

   wide_data_t ref_q[$];                 // Reference model of written words
   integer     seed = 27473;
   int         errors = 0;
   int         pass_count = 0;
   int         fail_count = 0;

   aib_adapttxdp_top uut (
      .wr_clk(wr_clk), .wr_rst_n(wr_rst_n), .wr_en(wr_en), .wr_data(wr_data),
      .rd_clk(rd_clk), .rd_rst_n(rd_rst_n), .rd_en(rd_en),
      .r_empty(r_empty), .r_pempty(r_pempty), .r_full(r_full), .r_pfull(r_pfull),
      .r_fifo_mode(r_fifo_mode), .rd_data(rd_data),
      .wr_empty(wr_empty), .wr_pempty(wr_pempty), .wr_full(wr_full), .wr_pfull(wr_pfull),
      .rd_empty(rd_empty), .rd_pempty(rd_pempty), .rd_full(rd_full), .rd_pfull(rd_pfull)
   );

   //****************************************
   // Clocks and watchdog
   //****************************************
   always #(clk_period/2) wr_clk = ~wr_clk;
   always @(wr_clk) rd_clk <= #3 wr_clk;   // Read clock trails write clock by 3 ns

   initial begin
      #(num_tests * budget_cycles * clk_period);
      $display("watchdog expired before the tests finished");
      $display("=== FAIL ===");
      $finish;
   end

   //****************************************
   // Compare tasks
   //****************************************
   task automatic check_lane(input string test, input lane_data_t exp, input lane_data_t act);
      if (act !== exp) begin
         $display("mismatch %s rd_data: expected %h actual %h", test, exp, act);
         errors++;
      end
   endtask

   task automatic check_flag(input string test, input string flag, input logic exp,
                             input logic act);
      if (act !== exp) begin
         $display("mismatch %s %s: expected %b actual %b", test, flag, exp, act);
         errors++;
      end
   endtask

   // Both domains share the expected levels
   task automatic check_all_flags(input string test, input logic e, input logic pe,
                                  input logic f, input logic pf);
      @(negedge wr_clk);
      check_flag(test, "wr_empty", e, wr_empty);
      check_flag(test, "wr_pempty", pe, wr_pempty);
      check_flag(test, "wr_full", f, wr_full);
      check_flag(test, "wr_pfull", pf, wr_pfull);
      @(negedge rd_clk);
      check_flag(test, "rd_empty", e, rd_empty);
      check_flag(test, "rd_pempty", pe, rd_pempty);
      check_flag(test, "rd_full", f, rd_full);
      check_flag(test, "rd_pfull", pf, rd_pfull);
   endtask

   //****************************************
   // Stimulus helpers
   //****************************************

   // Mode only ever changes while both domains sit in reset
   task automatic apply_reset(input fifo_mode_e mode);
      @(negedge wr_clk);
      wr_rst_n = 1'b0;
      wr_en    = 1'b0;
      @(negedge rd_clk);
      rd_rst_n    = 1'b0;
      rd_en       = 1'b0;
      r_fifo_mode = mode;                // Both resets now low
      repeat (5) @(negedge wr_clk);
      wr_rst_n = 1'b1;
      @(negedge rd_clk);
      rd_rst_n = 1'b1;
      ref_q.delete();
      repeat (2) @(negedge rd_clk);
   endtask

   task automatic push_words(input int count);
      wide_data_t word;
      for (int w = 0; w < count; w++) begin
         for (int k = 0; k < LANES * DWIDTH / 32; k++) begin
            word[k*32 +: 32] = $random(seed);   // 32 bits per call
         end
         @(negedge wr_clk);
         wr_data = word;
         wr_en   = 1'b1;
         ref_q.push_back(word);
      end
      @(negedge wr_clk);
      wr_en = 1'b0;
   endtask

   // Bounded wait for the synchronized write pointer
   task automatic wait_for_data(input string test);
      int cycles;
      cycles = 0;
      @(negedge rd_clk);
      while (rd_empty && cycles < 20) begin
         @(negedge rd_clk);
         cycles++;
      end
      if (rd_empty) begin
         $display("%s: read side never showed data", test);
         errors++;
      end
   endtask

   // One read per lane against the queued words
   task automatic pop_lanes(input string test, input int words, input int lanes);
      wide_data_t word;
      for (int w = 0; w < words; w++) begin
         word = ref_q.pop_front();
         for (int l = 0; l < lanes; l++) begin
            @(negedge rd_clk);
            check_lane(test, word[l*DWIDTH +: DWIDTH], rd_data);   // Before the pop
            rd_en = 1'b1;
         end
      end
      @(negedge rd_clk);
      rd_en = 1'b0;
   endtask

   task automatic report_test(input string test, input int errors_before);
      if (errors == errors_before) begin
         pass_count++;
         $display("test %s passed", test);
      end else begin
         fail_count++;
         $display("test %s failed with %0d errors", test, errors - errors_before);
      end
   endtask

   //****************************************
   // Tests
   //****************************************
   task automatic reset_flags();
      int start;
      start = errors;
      apply_reset(FIFO_1X);
      check_all_flags("reset_flags", 1'b1, 1'b1, 1'b0, 1'b0);
      report_test("reset_flags", start);
   endtask

   // Shared body for all ratio modes
   task automatic lane_order(input string test, input fifo_mode_e mode, input int words,
                             input int lanes);
      int start;
      start = errors;
      apply_reset(mode);
      push_words(words);
      wait_for_data(test);
      pop_lanes(test, words, lanes);
      report_test(test, start);
   endtask

   task automatic threshold_flags();
      int start;
      start = errors;
      apply_reset(FIFO_1X);
      push_words(8);                     // Occupancy reaches r_full
      repeat (8) @(negedge rd_clk);
      check_all_flags("threshold_flags", 1'b0, 1'b0, 1'b1, 1'b1);
      pop_lanes("threshold_flags", 7, 1);
      repeat (8) @(negedge rd_clk);      // Occupancy 1
      check_all_flags("threshold_flags", 1'b0, 1'b1, 1'b0, 1'b0);
      report_test("threshold_flags", start);
   endtask

   //****************************************
   // Main sequence
   //****************************************
   initial begin
      wr_rst_n    = 1'b0;
      rd_rst_n    = 1'b0;
      wr_en       = 1'b0;
      rd_en       = 1'b0;
      wr_data     = '0;
      r_empty     = ptr_t'(0);
      r_pempty    = ptr_t'(2);
      r_full      = ptr_t'(8);
      r_pfull     = ptr_t'(6);
      r_fifo_mode = FIFO_1X;

      reset_flags();
      lane_order("order_1to1", FIFO_1X, 10, 1);
      lane_order("order_2to1", FIFO_2X, 5, 2);
      lane_order("order_4to1", FIFO_4X, 4, 4);
      threshold_flags();
      lane_order("register_mode", REG_MOD, 6, 1);

      $display("tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0 && errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/aib_adapttxdp_pkg.sv
rtl/aib_adapttxdp_fifo_ram.sv
rtl/aib_adapttxdp_fifo_ptr.sv
rtl/aib_adapttxdp_async_fifo.sv
rtl/aib_adapttxdp_top.sv
dv/aib_adapttxdp_tb.sv
